// File: rdma_ig.f
+incdir+.
rdma_ig_pkg.sv
rdma_ig_cmd_ctrl.sv
rdma_ig_cube_walker.sv
rdma_ig_size_calc.sv
rdma_ig_addr_gen.sv
rdma_ig_stall_cnt.sv
rdma_ig_top.sv
rdma_ig_asserts.sv
rdma_ig_tb.sv

// File: rdma_ig_addr_gen.sv
// line and surface address walk
`default_nettype none

`include "rdma_ig_cfg.svh"

module rdma_ig_addr_gen (
  input  wire                         autosa_core_clk,
  input  wire                         autosa_core_rstn,
  input  wire                         op_load,
  input  wire rdma_ig_pkg::rdma_cfg_t cfg,
  input  wire                         cmd_accept,
  input  wire                         surf_end,
  output logic [`RDMA_ADDR_W-1:0]     req_addr
);

  // atom addresses
  logic [`RDMA_ADDR_W-`RDMA_ATOM_SHIFT-1:0] line_base;
  logic [`RDMA_ADDR_W-`RDMA_ATOM_SHIFT-1:0] surf_base;
  // start of the next surface
  logic [`RDMA_ADDR_W-`RDMA_ATOM_SHIFT-1:0] surf_next;

  assign surf_next = surf_base + cfg.surf_stride;

  // ==============================
  // line base
  // ==============================
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      line_base <= '0;
    end else if (op_load) begin
      line_base <= cfg.base_addr;
    end else if (cmd_accept) begin
      // new surface restarts the line walk
      if (surf_end) begin
        line_base <= surf_next;
      end else begin
        line_base <= line_base + cfg.line_stride;
      end
    end
  end

  // ==============================
  // surface base
  // ==============================
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      surf_base <= '0;
    end else if (op_load) begin
      surf_base <= cfg.base_addr;
    end else if (cmd_accept && surf_end) begin
      surf_base <= surf_next;
    end
  end

  // byte address of the current line
  assign req_addr = {line_base, {`RDMA_ATOM_SHIFT{1'b0}}};

endmodule

`default_nettype wire

// File: rdma_ig_asserts.sv
// read dma ingress protocol checks
`default_nettype none

module rdma_ig_asserts (
  input wire                         autosa_core_clk,
  input wire                         autosa_core_rstn,
  input wire rdma_ig_pkg::rdma_cfg_t cfg,
  input wire rdma_ig_pkg::dma_rd_req_t dma_rd_req_pd,
  input wire                         dma_rd_req_vld,
  input wire                         dma_rd_req_rdy,
  input wire rdma_ig_pkg::cq_pd_t    ig2cq_pd,
  input wire                         ig2cq_pvld,
  input wire                         ig2cq_prdy
);

  import rdma_ig_pkg::*;

  // failed checks so far
  int fail_cnt = 0;

  // request and context word move together
  accept_pair: assert property (@(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
    (dma_rd_req_vld && dma_rd_req_rdy) == (ig2cq_pvld && ig2cq_prdy))
    else begin
      fail_cnt++;
      $error("request and context accepts differ");
    end

  // no context offered without a request
  pvld_gated: assert property (@(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
    !(ig2cq_pvld && !dma_rd_req_vld && ig2cq_prdy))
    else begin
      fail_cnt++;
      $error("context valid without request valid");
    end

  // 16 bit data is never 1 byte wide
  legal_cfg: assert property (@(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
    !(cfg.op_en && cfg.precision != INT8 && cfg.data_size == SIZE_1BYTE))
    else begin
      fail_cnt++;
      $error("illegal precision and element size");
    end

  // stalled payload held
  pd_stable: assert property (@(posedge autosa_core_clk) disable iff (!autosa_core_rstn)
    (dma_rd_req_vld && !dma_rd_req_rdy) |=> ($stable(dma_rd_req_pd) && $stable(ig2cq_pd)))
    else begin
      fail_cnt++;
      $error("payload changed under back-pressure");
    end

endmodule

bind rdma_ig_top rdma_ig_asserts u_asserts (
  .autosa_core_clk (autosa_core_clk),
  .autosa_core_rstn(autosa_core_rstn),
  .cfg             (cfg),
  .dma_rd_req_pd   (dma_rd_req_pd),
  .dma_rd_req_vld  (dma_rd_req_vld),
  .dma_rd_req_rdy  (dma_rd_req_rdy),
  .ig2cq_pd        (ig2cq_pd),
  .ig2cq_pvld      (ig2cq_pvld),
  .ig2cq_prdy      (ig2cq_prdy)
);

`default_nettype wire

// File: rdma_ig_cfg.svh
// read dma ingress
// width settings
`ifndef RDMA_IG_CFG_SVH
`define RDMA_IG_CFG_SVH

// ==============================
// address
// ==============================
// byte address of a read request
`define RDMA_ADDR_W 64
// log2 of the 32 byte atom
`define RDMA_ATOM_SHIFT 5
// stride registers count whole atoms
`define RDMA_STRIDE_W 27

// ==============================
// cube shape and request
// ==============================
// channel, height and width fields (minus one)
`define RDMA_DIM_W 13
// request size in atoms minus one
`define RDMA_SIZE_W 15
// channel group counter
`define RDMA_CGRP_W 9
// perf counter
`define RDMA_STALL_W 32

`endif

// File: rdma_ig_cmd_ctrl.sv
// request issue control
`default_nettype none

module rdma_ig_cmd_ctrl (
  input  wire  autosa_core_clk,
  input  wire  autosa_core_rstn,
  input  wire  op_load,
  input  wire  cube_end,
  input  wire  dma_rd_req_rdy,
  input  wire  ig2cq_prdy,
  output logic dma_rd_req_vld,
  output logic ig2cq_pvld,
  output logic cmd_accept
);

  // operation in flight
  logic op_active;
  // last request of the cube taken
  logic op_done;

  // ==============================
  // operation active flag
  // ==============================
  assign op_done = cmd_accept & cube_end;

  // load wins over a done in the same cycle
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      op_active <= 1'b0;
    end else if (op_load) begin
      op_active <= 1'b1;
    end else if (op_done) begin
      op_active <= 1'b0;
    end
  end

  // ==============================
  // cross coupled valids
  // ==============================
  // request only offered while the context queue has room
  assign dma_rd_req_vld = op_active & ig2cq_prdy;
  // context only offered while dma takes the request
  assign ig2cq_pvld = op_active & dma_rd_req_rdy;

  // both sides transfer in this cycle
  // sole advance event for the walk
  assign cmd_accept = dma_rd_req_vld & dma_rd_req_rdy;

endmodule

`default_nettype wire

// File: rdma_ig_cube_walker.sv
// feature cube walk
`default_nettype none

`include "rdma_ig_cfg.svh"

module rdma_ig_cube_walker (
  input  wire                         autosa_core_clk,
  input  wire                         autosa_core_rstn,
  input  wire rdma_ig_pkg::rdma_cfg_t cfg,
  input  wire                         cmd_accept,
  input  wire [`RDMA_CGRP_W-1:0]      cgrp_last,
  output logic                        surf_end,
  output logic                        cube_end,
  output logic                        req_single
);

  import rdma_ig_pkg::*;

  // line within the current surface
  logic [`RDMA_DIM_W-1:0]  cnt_h;
  // channel group within the cube
  logic [`RDMA_CGRP_W-1:0] cnt_c;
  // one pixel cube packs into a single request
  logic                    mode_1x1_pack;
  logic                    last_h;
  logic                    last_c;

  // ==============================
  // shape decode
  // ==============================
  assign mode_1x1_pack = (cfg.width == '0) && (cfg.height == '0);
  assign req_single    = (cfg.data_mode == PER_KERNEL) || mode_1x1_pack;

  assign last_h = (cnt_h == cfg.height);
  assign last_c = (cnt_c == cgrp_last);

  // each request is one full line
  // straight request closes surface and cube at once
  assign surf_end = req_single | last_h;
  assign cube_end = req_single | (surf_end & last_c);

  // ==============================
  // height counter
  // ==============================
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      cnt_h <= '0;
    end else if (cmd_accept) begin
      if (surf_end) begin
        cnt_h <= '0;
      end else begin
        cnt_h <= cnt_h + 1'b1;
      end
    end
  end

  // ==============================
  // channel group counter
  // ==============================
  // steps once per surface, wraps at cube end
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      cnt_c <= '0;
    end else if (cmd_accept) begin
      if (cube_end) begin
        cnt_c <= '0;
      end else if (surf_end) begin
        cnt_c <= cnt_c + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: rdma_ig_pkg.sv
// read dma ingress types
`default_nettype none

`include "rdma_ig_cfg.svh"

package rdma_ig_pkg;

  // processing precision, fp16 sizes like int16
  typedef enum logic [1:0] {
    INT8  = 2'd0,
    INT16 = 2'd1,
    FP16  = 2'd2
  } proc_prec_e;

  // per kernel walks nothing, one straight request
  typedef enum logic {
    PER_KERNEL  = 1'b0,
    PER_ELEMENT = 1'b1
  } data_mode_e;

  typedef enum logic {
    SIZE_1BYTE = 1'b0,
    SIZE_2BYTE = 1'b1
  } data_size_e;

  typedef enum logic [1:0] {
    USE_SINGLE = 2'd0,
    USE_RSVD   = 2'd1,
    USE_BOTH   = 2'd2
  } data_use_e;

  // register settings, stable while the op runs
  typedef struct packed {
    logic                                  op_en;
    logic                                  perf_dma_en;
    proc_prec_e                            precision;
    data_mode_e                            data_mode;
    data_size_e                            data_size;
    data_use_e                             data_use;
    logic [`RDMA_DIM_W-1:0]                channel;
    logic [`RDMA_DIM_W-1:0]                height;
    logic [`RDMA_DIM_W-1:0]                width;
    // atom address
    logic [`RDMA_ADDR_W-`RDMA_ATOM_SHIFT-1:0] base_addr;
    logic [`RDMA_STRIDE_W-1:0]             line_stride;
    logic [`RDMA_STRIDE_W-1:0]             surf_stride;
  } rdma_cfg_t;

  // read request, size sits above the address
  typedef struct packed {
    logic [`RDMA_SIZE_W-1:0] size;
    logic [`RDMA_ADDR_W-1:0] addr;
  } dma_rd_req_t;

  // context word for the egress side
  typedef struct packed {
    logic                    cube_end;
    logic [`RDMA_SIZE_W-1:0] size;
  } cq_pd_t;

endpackage

`default_nettype wire

// File: rdma_ig_size_calc.sv
// request size in atoms
`default_nettype none

`include "rdma_ig_cfg.svh"

module rdma_ig_size_calc (
  input  wire rdma_ig_pkg::rdma_cfg_t cfg,
  input  wire                         req_single,
  output logic [`RDMA_CGRP_W-1:0]     cgrp_last,
  output logic [`RDMA_SIZE_W-1:0]     req_size
);

  import rdma_ig_pkg::*;

  logic                     prec_int8;
  logic                     size_1byte;
  logic                     use_both;
  // channel count in groups, full width before trim
  logic [`RDMA_DIM_W-1:0]   chan_grp;
  // log2 of atoms per element position
  logic [1:0]               elem_lg;
  logic [`RDMA_SIZE_W-1:0]  width_ext;
  logic [`RDMA_SIZE_W-1:0]  cgrp_ext;
  logic [`RDMA_SIZE_W-1:0]  line_size;
  logic [`RDMA_SIZE_W-1:0]  strt_size;

  // (n+1) * 2^lg - 1
  // gives n, 2n+1 or 4n+3
  function automatic logic [`RDMA_SIZE_W-1:0] scale_atoms(
    input logic [`RDMA_SIZE_W-1:0] n,
    input logic [1:0]              lg
  );
    scale_atoms = ((n + 1'b1) << lg) - 1'b1;
  endfunction

  // ==============================
  // config decode
  // ==============================
  assign prec_int8  = (cfg.precision == INT8);
  assign size_1byte = (cfg.data_size == SIZE_1BYTE);
  assign use_both   = (cfg.data_use == USE_BOTH);

  // 32 channels per atom for int8
  // 16 for int16 and fp16
  always_comb begin
    if (prec_int8) begin
      chan_grp = cfg.channel >> `RDMA_ATOM_SHIFT;
    end else begin
      chan_grp = cfg.channel >> (`RDMA_ATOM_SHIFT - 1);
    end
  end
  assign cgrp_last = chan_grp[`RDMA_CGRP_W-1:0];

  // int8: 2 byte data and both use each double the bytes
  // 16 bit: only both use doubles, element size ignored
  always_comb begin
    if (prec_int8) begin
      elem_lg = {1'b0, ~size_1byte} + {1'b0, use_both};
    end else begin
      elem_lg = {1'b0, use_both};
    end
  end

  // ==============================
  // line and straight sizes
  // ==============================
  assign width_ext = {{(`RDMA_SIZE_W-`RDMA_DIM_W){1'b0}}, cfg.width};
  assign cgrp_ext  = {{(`RDMA_SIZE_W-`RDMA_CGRP_W){1'b0}}, cgrp_last};

  assign line_size = scale_atoms(width_ext, elem_lg);

  // 16 bit with 1 byte size is not a legal setting
  // it still yields a defined size of 2C
  always_comb begin
    if (!prec_int8 && size_1byte) begin
      strt_size = cgrp_ext << 1;
    end else begin
      strt_size = scale_atoms(cgrp_ext, elem_lg);
    end
  end

  // straight request covers the whole channel column
  assign req_size = req_single ? strt_size : line_size;

endmodule

`default_nettype wire

// File: rdma_ig_stall_cnt.sv
// dma stall perf counter
`default_nettype none

`include "rdma_ig_cfg.svh"

module rdma_ig_stall_cnt (
  input  wire                         autosa_core_clk,
  input  wire                         autosa_core_rstn,
  input  wire rdma_ig_pkg::rdma_cfg_t cfg,
  input  wire                         op_load,
  input  wire                         dma_rd_req_vld,
  input  wire                         dma_rd_req_rdy,
  output logic [`RDMA_STALL_W-1:0]    dp2reg_rdma_stall
);

  // counting window
  logic cnt_en;
  // request offered but not taken
  logic stall;

  assign cnt_en = cfg.op_en & cfg.perf_dma_en;
  assign stall  = dma_rd_req_vld & ~dma_rd_req_rdy;

  // holds its value while disabled
  // load clears only inside the window
  always_ff @(posedge autosa_core_clk or negedge autosa_core_rstn) begin
    if (!autosa_core_rstn) begin
      dp2reg_rdma_stall <= '0;
    end else if (cnt_en) begin
      if (op_load) begin
        dp2reg_rdma_stall <= '0;
      end else if (stall) begin
        dp2reg_rdma_stall <= dp2reg_rdma_stall + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: rdma_ig_tb.sv
// read dma ingress testbench
`default_nettype none

`include "rdma_ig_cfg.svh"

module rdma_ig_tb;

  import rdma_ig_pkg::*;

  // requests over all tests: 12 + 9 + 8 + 8
  localparam int TOTAL_REQS     = 37;
  localparam int TIMEOUT_CYCLES = TOTAL_REQS * 8 + 200;

  logic                     autosa_core_clk;
  logic                     autosa_core_rstn;
  logic                     op_load;
  rdma_cfg_t                cfg;
  dma_rd_req_t              dma_rd_req_pd;
  logic                     dma_rd_req_vld;
  logic                     dma_rd_req_rdy;
  cq_pd_t                   ig2cq_pd;
  logic                     ig2cq_pvld;
  logic                     ig2cq_prdy;
  logic [`RDMA_STALL_W-1:0] dp2reg_rdma_stall;

  logic [31:0] rng;
  int          cycle_cnt;
  // expected requests, front is the next one
  logic [`RDMA_ADDR_W-1:0] exp_addr[$];
  logic [`RDMA_SIZE_W-1:0] exp_size[$];

  rdma_ig_top dut0 (
    .autosa_core_clk  (autosa_core_clk),
    .autosa_core_rstn (autosa_core_rstn),
    .op_load          (op_load),
    .cfg              (cfg),
    .dma_rd_req_pd    (dma_rd_req_pd),
    .dma_rd_req_vld   (dma_rd_req_vld),
    .dma_rd_req_rdy   (dma_rd_req_rdy),
    .ig2cq_pd         (ig2cq_pd),
    .ig2cq_pvld       (ig2cq_pvld),
    .ig2cq_prdy       (ig2cq_prdy),
    .dp2reg_rdma_stall(dp2reg_rdma_stall)
  );

  always #10 autosa_core_clk = ~autosa_core_clk;

  // hard stop on a hung walk
  always @(posedge autosa_core_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("TIMEOUT: run did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("Result: FAILED");
      $fatal(1, "timeout");
    end
  end

  // a failed protocol check ends the run
  always @(dut0.u_asserts.fail_cnt) begin
    if (dut0.u_asserts.fail_cnt != 0) begin
      abort_run("protocol assertion failed in the DUT");
    end
  end

  // ==============================
  // helpers
  // ==============================
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic report_mismatch(input string name, input logic [79:0] got,
                                 input logic [79:0] exp);
    $display("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp);
    $display("Result: FAILED");
    $fatal(1, "value mismatch");
  endtask

  task automatic check_value(input string name, input logic [79:0] got,
                             input logic [79:0] exp);
    assert (got == exp) else report_mismatch(name, got, exp);
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    lcg_next = s * 32'd1664525 + 32'd1013904223;
  endfunction

  // each ready high three times in four
  task automatic drive_random_ready();
    rng            = lcg_next(rng);
    dma_rd_req_rdy = (rng[31:30] != 2'b00);
    ig2cq_prdy     = (rng[29:28] != 2'b00);
  endtask

  function automatic rdma_cfg_t base_cfg();
    rdma_cfg_t c;
    c             = '0;
    c.op_en       = 1'b1;
    c.base_addr   = 'h12_3450;
    c.line_stride = 27'h40;
    c.surf_stride = 27'h800;
    base_cfg      = c;
  endfunction

  // reference walk, one entry per request
  task automatic build_expected(input rdma_cfg_t c);
    int   groups;
    int   mult;
    int   g;
    int   h;
    logic single;
    logic [`RDMA_ADDR_W-`RDMA_ATOM_SHIFT-1:0] atom;
    exp_addr.delete();
    exp_size.delete();
    // 32 int8 or 16 16-bit channels per atom
    groups = (c.precision == INT8) ? (c.channel / 32) + 1 : (c.channel / 16) + 1;
    // atoms per element position
    mult = (c.precision == INT8 && c.data_size == SIZE_2BYTE) ? 2 : 1;
    if (c.data_use == USE_BOTH) begin
      mult = mult * 2;
    end
    single = (c.data_mode == PER_KERNEL) || (c.width == 0 && c.height == 0);
    if (single) begin
      exp_addr.push_back({c.base_addr, {`RDMA_ATOM_SHIFT{1'b0}}});
      exp_size.push_back(groups * mult - 1);
    end else begin
      for (g = 0; g < groups; g++) begin
        for (h = 0; h <= c.height; h++) begin
          atom = c.base_addr + g * c.surf_stride + h * c.line_stride;
          exp_addr.push_back({atom, {`RDMA_ATOM_SHIFT{1'b0}}});
          exp_size.push_back((c.width + 1) * mult - 1);
        end
      end
    end
  endtask

  task automatic load_op(input rdma_cfg_t c);
    @(posedge autosa_core_clk);
    #1;
    cfg     = c;
    op_load = 1'b1;
    @(posedge autosa_core_clk);
    #1;
    op_load = 1'b0;
  endtask

  // checks each accept against the reference until the dut flags cube end
  task automatic drain_requests(input logic random_rdy, output int n_acc);
    logic [`RDMA_ADDR_W-1:0] a;
    logic [`RDMA_SIZE_W-1:0] s;
    logic                    seen_end;
    n_acc    = 0;
    seen_end = 1'b0;
    while (!seen_end) begin
      @(negedge autosa_core_clk);
      if (dma_rd_req_vld && dma_rd_req_rdy) begin
        assert (exp_addr.size() != 0)
          else abort_run("request issued past the expected cube end");
        a = exp_addr.pop_front();
        s = exp_size.pop_front();
        check_value("ig2cq_pvld", ig2cq_pvld, 1'b1);
        check_value("dma_rd_req_pd.addr", dma_rd_req_pd.addr, a);
        check_value("dma_rd_req_pd.size", dma_rd_req_pd.size, s);
        check_value("ig2cq_pd.size", ig2cq_pd.size, s);
        n_acc++;
        // first cube end closes the walk
        seen_end = ig2cq_pd.cube_end;
      end
      @(posedge autosa_core_clk);
      #1;
      if (random_rdy) begin
        drive_random_ready();
      end else begin
        dma_rd_req_rdy = 1'b1;
        ig2cq_prdy     = 1'b1;
      end
    end
    // op closed at the last accept
    check_value("dma_rd_req_vld", dma_rd_req_vld, 1'b0);
    check_value("ig2cq_pvld", ig2cq_pvld, 1'b0);
  endtask

  // ==============================
  // directed tests
  // ==============================
  task automatic test_reset();
    check_value("dma_rd_req_vld", dma_rd_req_vld, 1'b0);
    check_value("ig2cq_pvld", ig2cq_pvld, 1'b0);
    check_value("dp2reg_rdma_stall", dp2reg_rdma_stall, 0);
  endtask

  // 3 groups of 4 lines, size 4w+3
  task automatic test_int8_cube();
    rdma_cfg_t c;
    int        n;
    c           = base_cfg();
    c.data_mode = PER_ELEMENT;
    c.data_size = SIZE_2BYTE;
    c.data_use  = USE_BOTH;
    c.channel   = 13'd95;
    c.height    = 13'd3;
    c.width     = 13'd5;
    build_expected(c);
    load_op(c);
    drain_requests(1'b1, n);
    check_value("request count", n, 12);
  endtask

  // 47 >> 4 gives 3 groups of 3 lines
  task automatic test_int16_cube();
    rdma_cfg_t c;
    int        n;
    c           = base_cfg();
    c.precision = INT16;
    c.data_mode = PER_ELEMENT;
    c.data_size = SIZE_2BYTE;
    c.channel   = 13'd47;
    c.height    = 13'd2;
    c.width     = 13'd7;
    c.base_addr = 'h7_7000;
    build_expected(c);
    load_op(c);
    drain_requests(1'b1, n);
    check_value("request count", n, 9);
  endtask

  // int8 table, then 16 bit, last one a 1x1 pack
  task automatic test_straight();
    rdma_cfg_t c;
    int        n;
    int        k;
    for (k = 0; k < 8; k++) begin
      c         = base_cfg();
      c.channel = 13'd200;
      c.height  = 13'd4;
      c.width   = 13'd9;
      if (k < 4) begin
        c.data_size = data_size_e'(k[0]);
        c.data_use  = k[1] ? USE_BOTH : USE_SINGLE;
      end else begin
        c.precision = (k == 6) ? FP16 : INT16;
        c.data_size = SIZE_2BYTE;
        c.data_use  = (k == 5 || k == 6) ? USE_BOTH : USE_SINGLE;
      end
      if (k == 7) begin
        c.data_mode = PER_ELEMENT;
        c.width     = '0;
        c.height    = '0;
      end
      c.base_addr = c.base_addr + k * 'h100;
      build_expected(c);
      load_op(c);
      drain_requests(1'b1, n);
      check_value("request count", n, 1);
    end
  endtask

  task automatic test_backpressure();
    rdma_cfg_t c;
    int        n;
    c             = base_cfg();
    c.perf_dma_en = 1'b1;
    c.data_mode   = PER_ELEMENT;
    c.channel     = 13'd31;
    c.height      = 13'd3;
    c.width       = 13'd2;
    build_expected(c);
    load_op(c);
    // dma stalls: five counted cycles
    dma_rd_req_rdy = 1'b0;
    ig2cq_prdy     = 1'b1;
    repeat (5) begin
      @(negedge autosa_core_clk);
      check_value("dma_rd_req_vld", dma_rd_req_vld, 1'b1);
      @(posedge autosa_core_clk);
      #1;
    end
    // context queue full: no request, no advance
    dma_rd_req_rdy = 1'b1;
    ig2cq_prdy     = 1'b0;
    repeat (4) begin
      @(negedge autosa_core_clk);
      check_value("dma_rd_req_vld", dma_rd_req_vld, 1'b0);
      check_value("dma_rd_req_pd.addr", dma_rd_req_pd.addr, exp_addr[0]);
      @(posedge autosa_core_clk);
      #1;
    end
    check_value("dp2reg_rdma_stall", dp2reg_rdma_stall, 5);
    drain_requests(1'b0, n);
    check_value("request count", n, 4);
    check_value("dp2reg_rdma_stall", dp2reg_rdma_stall, 5);
    // reload clears, then three stalls
    build_expected(c);
    load_op(c);
    check_value("dp2reg_rdma_stall", dp2reg_rdma_stall, 0);
    dma_rd_req_rdy = 1'b0;
    ig2cq_prdy     = 1'b1;
    repeat (3) @(posedge autosa_core_clk);
    #1;
    check_value("dp2reg_rdma_stall", dp2reg_rdma_stall, 3);
    // perf off, count frozen
    c.perf_dma_en = 1'b0;
    cfg           = c;
    repeat (4) @(posedge autosa_core_clk);
    #1;
    check_value("dp2reg_rdma_stall", dp2reg_rdma_stall, 3);
    drain_requests(1'b0, n);
    check_value("request count", n, 4);
    check_value("dp2reg_rdma_stall", dp2reg_rdma_stall, 3);
  endtask

  // ==============================
  // main sequence
  // ==============================
  initial begin
    autosa_core_clk  = 1'b0;
    autosa_core_rstn = 1'b0;
    op_load          = 1'b0;
    cfg              = '0;
    dma_rd_req_rdy   = 1'b0;
    ig2cq_prdy       = 1'b0;
    rng              = 32'hc2b2_f2df;
    cycle_cnt        = 0;
    repeat (2) @(posedge autosa_core_clk);
    #1;
    autosa_core_rstn = 1'b1;
    test_reset();
    test_int8_cube();
    test_int16_cube();
    test_straight();
    test_backpressure();
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: rdma_ig_top.sv
// read dma ingress top
`default_nettype none

`include "rdma_ig_cfg.svh"

module rdma_ig_top (
  input  wire                         autosa_core_clk,
  input  wire                         autosa_core_rstn,
  input  wire                         op_load,
  input  wire rdma_ig_pkg::rdma_cfg_t cfg,
  output rdma_ig_pkg::dma_rd_req_t    dma_rd_req_pd,
  output logic                        dma_rd_req_vld,
  input  wire                         dma_rd_req_rdy,
  output rdma_ig_pkg::cq_pd_t         ig2cq_pd,
  output logic                        ig2cq_pvld,
  input  wire                         ig2cq_prdy,
  output logic [`RDMA_STALL_W-1:0]    dp2reg_rdma_stall
);

  logic                     cmd_accept;
  logic                     surf_end;
  logic                     cube_end;
  logic                     req_single;
  logic [`RDMA_CGRP_W-1:0]  cgrp_last;
  logic [`RDMA_SIZE_W-1:0]  req_size;
  logic [`RDMA_ADDR_W-1:0]  req_addr;

  // ==============================
  // control and walk
  // ==============================
  rdma_ig_cmd_ctrl u_cmd_ctrl (
    .autosa_core_clk (autosa_core_clk),
    .autosa_core_rstn(autosa_core_rstn),
    .op_load         (op_load),
    .cube_end        (cube_end),
    .dma_rd_req_rdy  (dma_rd_req_rdy),
    .ig2cq_prdy      (ig2cq_prdy),
    .dma_rd_req_vld  (dma_rd_req_vld),
    .ig2cq_pvld      (ig2cq_pvld),
    .cmd_accept      (cmd_accept)
  );

  rdma_ig_cube_walker u_cube_walker (
    .autosa_core_clk (autosa_core_clk),
    .autosa_core_rstn(autosa_core_rstn),
    .cfg             (cfg),
    .cmd_accept      (cmd_accept),
    .cgrp_last       (cgrp_last),
    .surf_end        (surf_end),
    .cube_end        (cube_end),
    .req_single      (req_single)
  );

  // ==============================
  // payload sources
  // ==============================
  rdma_ig_size_calc u_size_calc (
    .cfg       (cfg),
    .req_single(req_single),
    .cgrp_last (cgrp_last),
    .req_size  (req_size)
  );

  rdma_ig_addr_gen u_addr_gen (
    .autosa_core_clk (autosa_core_clk),
    .autosa_core_rstn(autosa_core_rstn),
    .op_load         (op_load),
    .cfg             (cfg),
    .cmd_accept      (cmd_accept),
    .surf_end        (surf_end),
    .req_addr        (req_addr)
  );

  rdma_ig_stall_cnt u_stall_cnt (
    .autosa_core_clk  (autosa_core_clk),
    .autosa_core_rstn (autosa_core_rstn),
    .cfg              (cfg),
    .op_load          (op_load),
    .dma_rd_req_vld   (dma_rd_req_vld),
    .dma_rd_req_rdy   (dma_rd_req_rdy),
    .dp2reg_rdma_stall(dp2reg_rdma_stall)
  );

  // request and context word carry the same size
  assign dma_rd_req_pd.addr = req_addr;
  assign dma_rd_req_pd.size = req_size;
  assign ig2cq_pd.size      = req_size;
  assign ig2cq_pd.cube_end  = cube_end;

endmodule

`default_nettype wire
